/* Makefile */
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tb_fir_bandpass
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* bench/tb_fir_bandpass.sv */
`default_nettype none

module tb_fir_bandpass;

  localparam int RESET_CYCLES = 8;
  localparam int MAX_STALL = 7;
  // impulse, random, back-pressure, reset split
  localparam int NUM_SAMPLES = 61 + 300 + 200 + 80;
  localparam int TIMEOUT_CYCLES = NUM_SAMPLES * (3 + MAX_STALL) + 4 * RESET_CYCLES + 500;
  localparam logic [31:0] LFSR_SEED = 32'd97867;

  logic                  clk;
  logic                  rst_n;
  logic                  s_valid;
  fir_data_pkg::sample_t s_data;
  logic                  s_ready;
  logic                  m_valid;
  fir_data_pkg::sample_t m_data;
  logic                  m_ready;

  logic [31:0] lfsr_state;
  logic        stall_on;
  int          stall_left;
  int          cycle_cnt;
  int          mis_main = 0;
  int          err_main = 0;
  int          mis_chk = 0;
  int          err_chk = 0;

  // model state owned by the compare process
  fir_data_pkg::tap_vec_t ref_hist;
  fir_data_pkg::sample_t  exp_q [$];
  logic                   acc_d1;
  logic                   acc_d2;
  logic                   prev_valid;
  logic                   prev_ready;
  fir_data_pkg::sample_t  prev_data;

  tb_clock_gen #(.PERIOD (8)) u_clock_gen (.clk (clk));

  fir_bandpass_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[14:0], lfsr_state[0]};
    end
  endtask

  function automatic fir_data_pkg::sample_t ref_filter(input fir_data_pkg::tap_vec_t hist);
    longint acc;
    acc = 0;
    for (int i = 0; i < fir_data_pkg::NUM_TAPS; i++)
    begin
      acc += longint'(hist[i]) * longint'(fir_coeff_pkg::COEFFS[i]);
    end
    // undo the 2^23 scaling and keep the low sample bits
    acc = acc >>> fir_coeff_pkg::SCALE_SHIFT_DEFAULT;
    return fir_data_pkg::sample_t'(acc[fir_data_pkg::SAMPLE_W-1:0]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one clock and the next m_ready value
  task automatic next_cycle();
    logic [15:0] bits;
    @(posedge clk);
    if (!stall_on)
      m_ready <= 1'b1;
    else if (stall_left > 0)
    begin
      m_ready <= 1'b0;
      stall_left--;
    end
    else
    begin
      // stall length 0 to MAX_STALL
      draw_bits(3, bits);
      stall_left = int'(bits[2:0]);
      m_ready <= 1'b1;
    end
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    s_valid <= 1'b0;
    s_data <= '0;
    m_ready <= 1'b1;
    repeat (RESET_CYCLES)
      next_cycle();
    rst_n <= 1'b1;
  endtask

  task automatic send_sample(input fir_data_pkg::sample_t value);
    s_valid <= 1'b1;
    s_data <= value;
    do
    begin
      next_cycle();
    end
    while (!s_ready);
    s_valid <= 1'b0;
  endtask

  task automatic send_random(input int n);
    logic [15:0] bits;
    for (int k = 0; k < n; k++)
    begin
      draw_bits(16, bits);
      send_sample(fir_data_pkg::sample_t'(bits));
    end
  endtask

  // until the last result has been taken
  task automatic wait_idle();
    do
    begin
      next_cycle();
    end
    while (!s_ready);
  endtask

  task automatic check_idle(input int n);
    repeat (n)
    begin
      next_cycle();
      if (!s_ready)
      begin
        mis_main++;
        $display("mismatch at %0t: s_ready expected 1 got 0", $time);
      end
      if (m_valid)
      begin
        mis_main++;
        $display("mismatch at %0t: m_valid expected 0 got 1", $time);
      end
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int mismatches;
    int others;
    mismatches = mis_main + mis_chk;
    others = err_main + err_chk;
    $display("errors: %0d mismatches, %0d other failures, timeout %0b",
             mismatches, others, timed_out);
    if (timed_out || (mismatches + others) > 0)
      $display("TESTS FAILED");
    else
      $display("TESTS PASSED");
    $finish;
  endtask

  initial
  begin
    lfsr_state = LFSR_SEED;
    stall_on = 1'b0;
    stall_left = 0;
    apply_reset();
    check_idle(10);
    // impulse response
    send_sample(16'sd32767);
    repeat (60)
      send_sample('0);
    wait_idle();
    send_random(300);
    wait_idle();
    // random back-pressure
    stall_on = 1'b1;
    send_random(200);
    wait_idle();
    // reset with a result still pending
    send_random(40);
    apply_reset();
    check_idle(5);
    send_random(40);
    wait_idle();
    next_cycle();
    if (exp_q.size() != 0)
    begin
      err_main++;
      $display("%0d expected results were never produced", exp_q.size());
    end
    finish_run(1'b0);
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

  //////////////////////////////////////////////////////////////////////
  // model update and compare
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    fir_data_pkg::sample_t expected;
    if (!rst_n)
    begin
      for (int i = 0; i < fir_data_pkg::NUM_TAPS; i++)
        ref_hist[i] = '0;
      exp_q.delete();
      acc_d1 = 1'b0;
      acc_d2 = 1'b0;
      prev_valid = 1'b0;
      prev_ready = 1'b1;
      prev_data = '0;
    end
    else
    begin
      // result offered one cycle after accept
      if (acc_d2 && !m_valid)
      begin
        mis_chk++;
        $display("mismatch at %0t: m_valid expected 1 got 0", $time);
      end
      if (m_valid && !prev_valid && !acc_d2)
      begin
        err_chk++;
        $display("m_valid rose at %0t without an accepted sample", $time);
      end
      // held under back-pressure
      if (prev_valid && !prev_ready && !m_valid)
      begin
        mis_chk++;
        $display("mismatch at %0t: m_valid expected 1 got 0 during stall", $time);
      end
      if (prev_valid && !prev_ready && m_valid && m_data !== prev_data)
      begin
        mis_chk++;
        $display("mismatch at %0t: m_data expected %0d got %0d during stall",
                 $time, prev_data, m_data);
      end
      if (m_valid && s_ready)
      begin
        mis_chk++;
        $display("mismatch at %0t: s_ready expected 0 got 1", $time);
      end
      if (m_valid && m_ready)
      begin
        if (exp_q.size() == 0)
        begin
          err_chk++;
          $display("output at %0t with no expected result", $time);
        end
        else
        begin
          expected = exp_q.pop_front();
          if (m_data !== expected)
          begin
            mis_chk++;
            $display("mismatch at %0t: m_data expected %0d got %0d",
                     $time, expected, m_data);
          end
        end
      end
      if (s_valid && s_ready)
      begin
        for (int i = fir_data_pkg::NUM_TAPS - 1; i > 0; i--)
          ref_hist[i] = ref_hist[i-1];
        ref_hist[0] = s_data;
        exp_q.push_back(ref_filter(ref_hist));
      end
      acc_d2 = acc_d1;
      acc_d1 = s_valid && s_ready;
      prev_valid = m_valid;
      prev_ready = m_ready;
      prev_data = m_data;
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
verilog/fir_data_pkg.sv
verilog/fir_coeff_pkg.sv
verilog/fir_flow_ctrl.sv
verilog/fir_tap_line.sv
verilog/fir_mac.sv
verilog/fir_bandpass_top.sv
bench/tb_clock_gen.sv
bench/tb_fir_bandpass.sv

/* include/fir_coeff_table.svh */
`ifndef FIR_COEFF_TABLE_SVH
`define FIR_COEFF_TABLE_SVH

//////////////////////////////////////////////////////////////////////
// bandpass taps, 2 Hz to 48 Hz passband at 500 Hz sample rate
//////////////////////////////////////////////////////////////////////

// tap 0 first, symmetric about tap 25
// values are the real coefficients times 2^23
`define FIR_COEFF_TABLE '{ \
  0, \
  3488, \
  4584, \
  1657, \
  -7004, \
  -21544, \
  -38844, \
  -52147, \
  -52988, \
  -35280, \
  0, \
  41968, \
  71124, \
  65590, \
  10873, \
  -90396, \
  -213161, \
  -312565, \
  -335311, \
  -237025, \
  0, \
  355329, \
  770299, \
  1160719, \
  1439189, \
  1540115, \
  1439189, \
  1160719, \
  770299, \
  355329, \
  0, \
  -237025, \
  -335311, \
  -312565, \
  -213161, \
  -90396, \
  10873, \
  65590, \
  71124, \
  41968, \
  0, \
  -35280, \
  -52988, \
  -52147, \
  -38844, \
  -21544, \
  -7004, \
  1657, \
  4584, \
  3488, \
  0 \
}

`endif

/* verilog/fir_bandpass_top.sv */
`default_nettype none

module fir_bandpass_top #(
  parameter int SCALE_SHIFT = fir_coeff_pkg::SCALE_SHIFT_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // input stream
  input  wire logic                  s_valid,
  input  wire fir_data_pkg::sample_t s_data,
  output logic                       s_ready,

  // output stream
  output logic                       m_valid,
  output fir_data_pkg::sample_t      m_data,
  input  wire logic                  m_ready
);

  //////////////////////////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////////////////////////

  logic                   shift_en;
  logic                   load_en;
  fir_data_pkg::tap_vec_t taps;

  //////////////////////////////////////////////////////////////////////
  // handshake control
  //////////////////////////////////////////////////////////////////////

  fir_flow_ctrl u_flow_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_valid  (s_valid),
    .m_ready  (m_ready),
    .s_ready  (s_ready),
    .m_valid  (m_valid),
    .shift_en (shift_en),
    .load_en  (load_en)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // shifts on the accept edge
  fir_tap_line u_tap_line (
    .clk      (clk),
    .rst_n    (rst_n),
    .shift_en (shift_en),
    .sample   (s_data),
    .taps     (taps)
  );

  // registers the filtered sample one cycle later
  fir_mac #(
    .SCALE_SHIFT (SCALE_SHIFT)
  ) u_mac (
    .clk     (clk),
    .rst_n   (rst_n),
    .load_en (load_en),
    .taps    (taps),
    .result  (m_data)
  );

endmodule

`default_nettype wire

/* verilog/fir_coeff_pkg.sv */
`default_nettype none

package fir_coeff_pkg;

  `include "fir_coeff_table.svh"

  //////////////////////////////////////////////////////////////////////
  // coefficient format
  //////////////////////////////////////////////////////////////////////

  localparam int COEFF_W = 25;

  typedef logic signed [COEFF_W-1:0] coeff_t;

  // table was scaled by 2^23
  localparam int SCALE_SHIFT_DEFAULT = 23;

  //////////////////////////////////////////////////////////////////////
  // coefficient table
  //////////////////////////////////////////////////////////////////////

  // index matches the tap index of the delay line
  localparam coeff_t COEFFS [fir_data_pkg::NUM_TAPS] = `FIR_COEFF_TABLE;

endpackage

`default_nettype wire

/* verilog/fir_data_pkg.sv */
`default_nettype none

package fir_data_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample stream
  //////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W = 16;
  localparam int NUM_TAPS = 51;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // newest sample at index 0
  typedef sample_t tap_vec_t [NUM_TAPS];

  //////////////////////////////////////////////////////////////////////
  // accumulator
  //////////////////////////////////////////////////////////////////////

  // 16-bit sample times 25-bit coefficient
  // the abs sum of the bandpass table at full scale input fits here
  localparam int ACC_W = 41;

  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

/* verilog/fir_flow_ctrl.sv */
`default_nettype none

module fir_flow_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic s_valid,
  input  wire logic m_ready,
  output logic      s_ready,
  output logic      m_valid,
  output logic      shift_en,
  output logic      load_en
);

  //////////////////////////////////////////////////////////////////////
  // state encoding
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_COMPUTE = 2'd1;
  localparam logic [1:0] ST_HOLD    = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;

  // sample taken on this edge
  logic accept;

  // result taken on this edge
  logic drain;

  assign accept = (state == ST_IDLE) && s_valid;
  assign drain  = (state == ST_HOLD) && m_ready;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (accept)
          state_nxt = ST_COMPUTE;
      end
      // single cycle, MAC loads the new sum
      ST_COMPUTE:
      begin
        state_nxt = ST_HOLD;
      end
      // wait here until downstream takes the result
      ST_HOLD:
      begin
        if (drain)
          state_nxt = ST_IDLE;
      end
      default:
      begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  //////////////////////////////////////////////////////////////////////
  // outputs decoded from state
  //////////////////////////////////////////////////////////////////////

  assign s_ready  = (state == ST_IDLE);
  assign m_valid  = (state == ST_HOLD);
  assign shift_en = accept;
  assign load_en  = (state == ST_COMPUTE);

endmodule

`default_nettype wire

/* verilog/fir_mac.sv */
`default_nettype none

module fir_mac #(
  parameter int SCALE_SHIFT = fir_coeff_pkg::SCALE_SHIFT_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  load_en,
  input  wire fir_data_pkg::tap_vec_t taps,
  output fir_data_pkg::sample_t      result
);

  fir_data_pkg::acc_t prod [fir_data_pkg::NUM_TAPS];
  fir_data_pkg::acc_t sum;
  fir_data_pkg::acc_t scaled;

  //////////////////////////////////////////////////////////////////////
  // products
  //////////////////////////////////////////////////////////////////////

  // both operands sign extended to full width first
  always_comb
  begin
    for (int i = 0; i < fir_data_pkg::NUM_TAPS; i++)
    begin
      prod[i] = fir_data_pkg::acc_t'(taps[i]) *
                fir_data_pkg::acc_t'(fir_coeff_pkg::COEFFS[i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accumulate and scale
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sum = '0;
    for (int i = 0; i < fir_data_pkg::NUM_TAPS; i++)
    begin
      sum = sum + prod[i];
    end
  end

  // arithmetic shift undoes the coefficient scaling
  assign scaled = sum >>> SCALE_SHIFT;

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // loads once per sample, holds through any stall
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      result <= '0;
    else if (load_en)
      result <= scaled[fir_data_pkg::SAMPLE_W-1:0];
  end

endmodule

`default_nettype wire

/* verilog/fir_tap_line.sv */
`default_nettype none

module fir_tap_line (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 shift_en,
  input  wire fir_data_pkg::sample_t sample,
  output fir_data_pkg::tap_vec_t    taps
);

  //////////////////////////////////////////////////////////////////////
  // sample history
  //////////////////////////////////////////////////////////////////////

  // index 0 holds the newest accepted sample
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < fir_data_pkg::NUM_TAPS; i++)
      begin
        taps[i] <= '0;
      end
    end
    else if (shift_en)
    begin
      taps[0] <= sample;
      // oldest sample falls off the end
      for (int i = 1; i < fir_data_pkg::NUM_TAPS; i++)
      begin
        taps[i] <= taps[i-1];
      end
    end
  end

endmodule

`default_nettype wire
